// ==== bench/tb_clock.sv ====
module tb_clock (
    output logic clk
);
    localparam int half_period = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

// ==== bench/tb_execute.sv ====
module tb_execute;
    import rv32i_pkg::*;
    import ooo_pkg::*;

    localparam int          n_issue    = 2000;
    localparam int          clk_period = 10;
    localparam logic [31:0] seed       = 32'head91c07;

    // due is the cycle count at which the beat shows up
    typedef struct packed {
        int          due;
        fu_tag_t     tag;
        logic [31:0] val;
    } exp_t;

    logic                     clk;
    logic                     rst;
    logic                     start_alu, start_mul, start_div;
    alu_op_t                  op_alu;
    mul_op_t                  mul_op;
    div_op_t                  div_op;
    logic [xlen-1:0]          rs1_v_alu, rs2_v_alu, rs1_v_mul, rs2_v_mul, rs1_v_div, rs2_v_div;
    logic [rob_idx_bits-1:0]  rob_idx_alu, rob_idx_mul, rob_idx_div;
    logic [phys_reg_bits-1:0] pd_alu, pd_mul, pd_div;
    logic [4:0]               rd_alu, rd_mul, rd_div;
    cdb_t                     cdb_alu, cdb_mul, cdb_div;
    logic                     div_busy;

    int   cyc = 0;
    exp_t alu_q [$];
    exp_t mul_q [$];
    exp_t div_q [$];
    exp_t none = '{due: -1, default: '0};

    tb_clock u_clock (.clk(clk));

    execute i_dut (
        .op_mul (mul_op),
        .op_div (div_op),
        .*
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic stop_fail();
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] rand_operand();
        if ($urandom_range(7) != 0) begin
            return $urandom;
        end
        case ($urandom_range(3))
            0: return 32'h0;
            1: return 32'h1;
            2: return 32'hffffffff;
            default: return 32'h80000000;
        endcase
    endfunction

    function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_sra:  return (a >> b[4:0]) | (~(32'hffffffff >> b[4:0]) & {32{a[31]}});
            op_slt:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            op_sltu: return {31'b0, a < b};
            default: return 32'h0;
        endcase
    endfunction

    // low or high word of the 64 bit product of the extended operands
    function automatic logic [31:0] mul_model(mul_op_t op, logic [31:0] a, logic [31:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = {((op == op_mulh || op == op_mulhsu) && a[31]) ? 32'hffffffff : 32'h0, a};
        eb = {(op == op_mulh && b[31]) ? 32'hffffffff : 32'h0, b};
        p  = ea * eb;
        return (op == op_mul) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [31:0] div_model(div_op_t op, logic [31:0] a, logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        r;
        sa = a;
        sb = b;
        if (b == 32'h0) begin
            return (op == op_div || op == op_divu) ? 32'hffffffff : a;
        end
        // signed overflow of the most negative value over -1
        if (a == 32'h80000000 && b == 32'hffffffff && (op == op_div || op == op_rem)) begin
            return (op == op_div) ? a : 32'h0;
        end
        case (op)
            op_div:  r = sa / sb;
            op_divu: r = a / b;
            op_rem:  r = sa % sb;
            default: r = a % b;
        endcase
        return r;
    endfunction

    task automatic check_beat(input string name, input cdb_t cdb, input exp_t head);
        bit due_now;
        due_now = (head.due == cyc);
        assert (cdb.valid == due_now) else begin
            if (cdb.valid) begin
                $display("%s valid strobe at cycle %0d without a matching issue", name, cyc);
            end else begin
                $display("%s result missing at cycle %0d", name, cyc);
            end
            stop_fail();
        end
        if (due_now) begin
            assert (cdb.tag == head.tag) else begin
                $display("ERR %s.tag got %h exp %h", name, cdb.tag, head.tag);
                stop_fail();
            end
            assert (cdb.rd_v == head.val) else begin
                $display("ERR %s.rd_v got %h exp %h", name, cdb.rd_v, head.val);
                stop_fail();
            end
        end
    endtask

    // check this cycle's beats, then drive the next issues
    task automatic step(input bit issue);
        @(negedge clk);
        check_beat("cdb_alu", cdb_alu, alu_q.size() != 0 ? alu_q[0] : none);
        check_beat("cdb_mul", cdb_mul, mul_q.size() != 0 ? mul_q[0] : none);
        check_beat("cdb_div", cdb_div, div_q.size() != 0 ? div_q[0] : none);
        if (cdb_alu.valid) alu_q.delete(0);
        if (cdb_mul.valid) mul_q.delete(0);
        if (cdb_div.valid) div_q.delete(0);
        assert (div_busy == (div_q.size() != 0)) else begin
            $display("ERR div_busy got %h exp %h", div_busy, div_q.size() != 0);
            stop_fail();
        end

        start_alu = issue && ($urandom_range(1) == 1);
        op_alu    = alu_op_t'(4'($urandom_range(9)));
        rs1_v_alu = rand_operand();
        rs2_v_alu = rand_operand();
        {rob_idx_alu, pd_alu, rd_alu} = 17'($urandom);
        if (start_alu) begin
            alu_q.push_back('{due: cyc + 1, tag: {rob_idx_alu, pd_alu, rd_alu},
                              val: alu_model(op_alu, rs1_v_alu, rs2_v_alu)});
        end

        start_mul = issue && ($urandom_range(1) == 1);
        mul_op    = mul_op_t'(2'($urandom));
        rs1_v_mul = rand_operand();
        rs2_v_mul = rand_operand();
        {rob_idx_mul, pd_mul, rd_mul} = 17'($urandom);
        if (start_mul) begin
            mul_q.push_back('{due: cyc + mul_latency, tag: {rob_idx_mul, pd_mul, rd_mul},
                              val: mul_model(mul_op, rs1_v_mul, rs2_v_mul)});
        end

        start_div = issue && !div_busy;
        div_op    = div_op_t'(2'($urandom));
        rs1_v_div = rand_operand();
        rs2_v_div = rand_operand();
        {rob_idx_div, pd_div, rd_div} = 17'($urandom);
        if (start_div) begin
            div_q.push_back('{due: cyc + div_latency, tag: {rob_idx_div, pd_div, rd_div},
                              val: div_model(div_op, rs1_v_div, rs2_v_div)});
        end
    endtask

    initial begin
        void'($urandom(seed));
        rst = 1'b1;
        {start_alu, start_mul, start_div} = 3'b000;
        op_alu = op_add;
        mul_op = op_mul;
        div_op = op_div;
        {rs1_v_alu, rs2_v_alu, rs1_v_mul, rs2_v_mul, rs1_v_div, rs2_v_div} = '0;
        {rob_idx_alu, pd_alu, rd_alu, rob_idx_mul, pd_mul, rd_mul} = '0;
        {rob_idx_div, pd_div, rd_div} = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_issue; i++) begin
            step(1'b1);
        end
        // no new issues while the units drain
        while (alu_q.size() != 0 || mul_q.size() != 0 || div_q.size() != 0) begin
            step(1'b0);
        end
        repeat (4) step(1'b0);

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #((n_issue + div_latency + 20) * clk_period);
        $display("timeout, the run did not finish in time");
        stop_fail();
    end

endmodule

// ==== hdl/execute.sv ====
module execute (
    input  logic                              clk,
    input  logic                              rst,

    // alu issue
    input  logic                              start_alu,
    input  rv32i_pkg::alu_op_t                op_alu,
    input  logic [rv32i_pkg::xlen-1:0]        rs1_v_alu,
    input  logic [rv32i_pkg::xlen-1:0]        rs2_v_alu,
    input  logic [ooo_pkg::rob_idx_bits-1:0]  rob_idx_alu,
    input  logic [ooo_pkg::phys_reg_bits-1:0] pd_alu,
    input  logic [4:0]                        rd_alu,

    // multiplier issue
    input  logic                              start_mul,
    input  rv32i_pkg::mul_op_t                op_mul,
    input  logic [rv32i_pkg::xlen-1:0]        rs1_v_mul,
    input  logic [rv32i_pkg::xlen-1:0]        rs2_v_mul,
    input  logic [ooo_pkg::rob_idx_bits-1:0]  rob_idx_mul,
    input  logic [ooo_pkg::phys_reg_bits-1:0] pd_mul,
    input  logic [4:0]                        rd_mul,

    // divider issue
    input  logic                              start_div,
    input  rv32i_pkg::div_op_t                op_div,
    input  logic [rv32i_pkg::xlen-1:0]        rs1_v_div,
    input  logic [rv32i_pkg::xlen-1:0]        rs2_v_div,
    input  logic [ooo_pkg::rob_idx_bits-1:0]  rob_idx_div,
    input  logic [ooo_pkg::phys_reg_bits-1:0] pd_div,
    input  logic [4:0]                        rd_div,

    output ooo_pkg::cdb_t                     cdb_alu,
    output ooo_pkg::cdb_t                     cdb_mul,
    output ooo_pkg::cdb_t                     cdb_div,
    output logic                              div_busy
);
    import rv32i_pkg::*;

    fu_issue_if #(.op_t(alu_op_t)) alu_iss ();
    fu_issue_if #(.op_t(mul_op_t)) mul_iss ();
    fu_issue_if #(.op_t(div_op_t)) div_iss ();

    assign alu_iss.start = start_alu;
    assign alu_iss.op    = op_alu;
    assign alu_iss.rs1_v = rs1_v_alu;
    assign alu_iss.rs2_v = rs2_v_alu;
    assign alu_iss.tag   = '{rob_idx: rob_idx_alu, pd: pd_alu, rd: rd_alu};

    assign mul_iss.start = start_mul;
    assign mul_iss.op    = op_mul;
    assign mul_iss.rs1_v = rs1_v_mul;
    assign mul_iss.rs2_v = rs2_v_mul;
    assign mul_iss.tag   = '{rob_idx: rob_idx_mul, pd: pd_mul, rd: rd_mul};

    assign div_iss.start = start_div;
    assign div_iss.op    = op_div;
    assign div_iss.rs1_v = rs1_v_div;
    assign div_iss.rs2_v = rs2_v_div;
    assign div_iss.tag   = '{rob_idx: rob_idx_div, pd: pd_div, rd: rd_div};

    fu_alu u_alu (
        .clk (clk),
        .rst (rst),
        .iss (alu_iss.unit),
        .cdb (cdb_alu)
    );

    fu_mult u_mult (
        .clk (clk),
        .rst (rst),
        .iss (mul_iss.unit),
        .cdb (cdb_mul)
    );

    fu_div_rem u_div_rem (
        .clk  (clk),
        .rst  (rst),
        .iss  (div_iss.unit),
        .cdb  (cdb_div),
        .busy (div_busy)
    );

endmodule

// ==== hdl/fu_alu.sv ====
module fu_alu (
    input  logic          clk,
    input  logic          rst,
    fu_issue_if.unit      iss,
    output ooo_pkg::cdb_t cdb
);
    import rv32i_pkg::*;

    logic [xlen-1:0]         res;
    logic [$clog2(xlen)-1:0] shamt;

    // only the low bits of rs2 count for shifts
    assign shamt = iss.rs2_v[$clog2(xlen)-1:0];

    always_comb begin
        case (iss.op)
            op_add:  res = iss.rs1_v + iss.rs2_v;
            op_sub:  res = iss.rs1_v - iss.rs2_v;
            op_and:  res = iss.rs1_v & iss.rs2_v;
            op_or:   res = iss.rs1_v | iss.rs2_v;
            op_xor:  res = iss.rs1_v ^ iss.rs2_v;
            op_sll:  res = iss.rs1_v << shamt;
            op_srl:  res = iss.rs1_v >> shamt;
            op_sra:  res = $unsigned($signed(iss.rs1_v) >>> shamt);
            op_slt: begin
                res = {{(xlen-1){1'b0}}, $signed(iss.rs1_v) < $signed(iss.rs2_v)};
            end
            op_sltu: begin
                res = {{(xlen-1){1'b0}}, iss.rs1_v < iss.rs2_v};
            end
            default: res = '0;
        endcase
    end

    // one result beat per issued cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb <= '0;
        end else begin
            cdb.valid <= iss.start;
            if (iss.start) begin
                cdb.tag  <= iss.tag;
                cdb.rd_v <= res;
            end
        end
    end

endmodule

// ==== hdl/fu_div_rem.sv ====
module fu_div_rem (
    input  logic          clk,
    input  logic          rst,
    fu_issue_if.unit      iss,
    output ooo_pkg::cdb_t cdb,
    output logic          busy
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    localparam int cnt_bits = $clog2(div_latency);

    // latch cycle and fixup cycle bracket the shift-subtract steps
    localparam logic [cnt_bits-1:0] last_step = cnt_bits'(div_latency - 2);

    logic [cnt_bits-1:0] cnt;
    logic [xlen-1:0]     dvd_q;     // dividend in, quotient out
    logic [xlen-1:0]     dvs_q;
    logic [xlen-1:0]     rem_q;
    logic                neg_q;
    logic                neg_r;
    logic                is_rem;
    logic                div_zero;
    fu_tag_t             tag_q;

    logic                is_signed;
    logic                accept;
    logic [xlen-1:0]     rs1_mag;
    logic [xlen-1:0]     rs2_mag;
    logic [xlen:0]       rem_sh;
    logic [xlen+1:0]     diff;
    logic [xlen-1:0]     quo_res;
    logic [xlen-1:0]     rem_res;

    always_comb begin
        accept    = iss.start && !busy;
        is_signed = (iss.op == op_div) || (iss.op == op_rem);
        rs1_mag   = (is_signed && iss.rs1_v[xlen-1]) ? -iss.rs1_v : iss.rs1_v;
        rs2_mag   = (is_signed && iss.rs2_v[xlen-1]) ? -iss.rs2_v : iss.rs2_v;

        // trial subtract, top bit set means it did not fit
        rem_sh = {rem_q, dvd_q[xlen-1]};
        diff   = {1'b0, rem_sh} - {2'b00, dvs_q};

        // most negative / -1 needs no special path: 0x80000000 / 1 with
        // equal signs already gives the dividend and a zero remainder
        quo_res = neg_q ? -dvd_q : dvd_q;
        if (div_zero) begin
            quo_res = '1;
        end
        rem_res = neg_r ? -rem_q : rem_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            cdb  <= '0;
        end else begin
            cdb.valid <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (cnt == last_step) begin
                    busy      <= 1'b0;
                    cdb.valid <= 1'b1;
                    cdb.tag   <= tag_q;
                    cdb.rd_v  <= is_rem ? rem_res : quo_res;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dvd_q    <= rs1_mag;
            dvs_q    <= rs2_mag;
            rem_q    <= '0;
            neg_q    <= is_signed && (iss.rs1_v[xlen-1] ^ iss.rs2_v[xlen-1]);
            neg_r    <= is_signed && iss.rs1_v[xlen-1];
            is_rem   <= (iss.op == op_rem) || (iss.op == op_remu);
            div_zero <= (iss.rs2_v == '0);
            tag_q    <= iss.tag;
        end else if (busy && cnt != last_step) begin
            dvd_q <= {dvd_q[xlen-2:0], !diff[xlen+1]};
            rem_q <= diff[xlen+1] ? rem_sh[xlen-1:0] : diff[xlen-1:0];
        end
    end

endmodule

// ==== hdl/fu_issue_if.sv ====
interface fu_issue_if #(
    parameter type op_t = logic [1:0]
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    // start is a one cycle strobe, the rest is only meaningful with it
    logic            start;
    op_t             op;
    logic [xlen-1:0] rs1_v;
    logic [xlen-1:0] rs2_v;
    fu_tag_t         tag;

    modport top (
        output start,
        output op,
        output rs1_v,
        output rs2_v,
        output tag
    );

    modport unit (
        input start,
        input op,
        input rs1_v,
        input rs2_v,
        input tag
    );

endinterface

// ==== hdl/fu_mult.sv ====
module fu_mult (
    input  logic          clk,
    input  logic          rst,
    fu_issue_if.unit      iss,
    output ooo_pkg::cdb_t cdb
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    // valid and tag for the stages ahead of the cdb register
    logic [mul_latency-2:0] vld_q;
    fu_tag_t                tag_q [mul_latency-1];

    mul_op_t                  op1_q;
    mul_op_t                  op2_q;
    logic signed [xlen:0]     a_q;
    logic signed [xlen:0]     b_q;
    logic signed [2*xlen+1:0] prod_q;
    logic                     a_sgn;
    logic                     b_sgn;

    // low word is the same either way, so mul extends with zeros
    assign a_sgn = (iss.op == op_mulh) || (iss.op == op_mulhsu);
    assign b_sgn = (iss.op == op_mulh);

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
            cdb   <= '0;
        end else begin
            vld_q     <= {vld_q[mul_latency-3:0], iss.start};
            cdb.valid <= vld_q[mul_latency-2];
            if (vld_q[mul_latency-2]) begin
                cdb.tag <= tag_q[mul_latency-2];
                // stage three picks the word
                if (op2_q == op_mul) begin
                    cdb.rd_v <= prod_q[xlen-1:0];
                end else begin
                    cdb.rd_v <= prod_q[2*xlen-1:xlen];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        // stage one, extend to 33 bits
        a_q      <= {a_sgn & iss.rs1_v[xlen-1], iss.rs1_v};
        b_q      <= {b_sgn & iss.rs2_v[xlen-1], iss.rs2_v};
        op1_q    <= iss.op;
        tag_q[0] <= iss.tag;

        // stage two, full signed product
        prod_q <= a_q * b_q;
        op2_q  <= op1_q;
        for (int i = 1; i < mul_latency - 1; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
    end

endmodule

// ==== hdl/ooo_pkg.sv ====
package ooo_pkg;

    localparam int rob_idx_bits  = 6;
    localparam int phys_reg_bits = 6;

    // cycles from start sample to result beat, counted as registers
    localparam int mul_latency = 3;
    localparam int div_latency = 34;

    // bookkeeping that rides along with every operation
    typedef struct packed {
        logic [rob_idx_bits-1:0]  rob_idx;
        logic [phys_reg_bits-1:0] pd;
        logic [4:0]               rd;
    } fu_tag_t;

    typedef struct packed {
        logic                       valid;
        fu_tag_t                    tag;
        logic [rv32i_pkg::xlen-1:0] rd_v;
    } cdb_t;

endpackage

// ==== hdl/rv32i_pkg.sv ====
package rv32i_pkg;

    localparam int xlen = 32;

    // integer alu operations
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9
    } alu_op_t;

    // m extension, multiply group
    typedef enum logic [1:0] {
        op_mul    = 2'd0,
        op_mulh   = 2'd1,
        op_mulhsu = 2'd2,
        op_mulhu  = 2'd3
    } mul_op_t;

    // m extension, divide group
    typedef enum logic [1:0] {
        op_div  = 2'd0,
        op_divu = 2'd1,
        op_rem  = 2'd2,
        op_remu = 2'd3
    } div_op_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_execute -o sim_execute

# the simulation exits non-zero on failure, the log decides
./obj_dir/sim_execute > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// ==== sim.f ====
hdl/rv32i_pkg.sv
hdl/ooo_pkg.sv
hdl/fu_issue_if.sv
hdl/fu_alu.sv
hdl/fu_mult.sv
hdl/fu_div_rem.sv
hdl/execute.sv
bench/tb_clock.sv
bench/tb_execute.sv
